// ==== src.f ====
mips_id_pkg.sv
decode_if.sv
inst_intake.sv
inst_decoder.sv
operand_issue.sv
mips_id_top.sv
tb_mips_id.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with verilator, run, then judge the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module tb_mips_id \
    && ./obj_dir/Vtb_mips_id | tee sim.log \
    || { echo "build or simulation error"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tb_mips_id.sv ====
module tb_mips_id import mips_id_pkg::*; ();

    typedef struct packed {
        logic [ALUOP_W-1:0]    aluop;
        logic [ALUSEL_W-1:0]   alusel;
        logic [REG_DATA_W-1:0] op1;
        logic [REG_DATA_W-1:0] op2;
        logic [REG_ADDR_W-1:0] wr_addr;
        logic                  wr_en;
        logic                  valid;
    } result_t;

    // what the execute and memory stages offer for forwarding.
    typedef struct packed {
        logic [REG_ADDR_W-1:0] ex_a;
        logic [REG_DATA_W-1:0] ex_d;
        logic                  ex_w;
        logic [REG_ADDR_W-1:0] mem_a;
        logic [REG_DATA_W-1:0] mem_d;
        logic                  mem_w;
    } fwd_t;

    logic                  clk;
    logic                  rst_n;
    logic                  in_req;
    logic [INST_W-1:0]     inst;
    logic                  in_ack;
    logic [REG_ADDR_W-1:0] reg_rd_addr1;
    logic [REG_ADDR_W-1:0] reg_rd_addr2;
    logic [REG_DATA_W-1:0] reg_rd_data1;
    logic [REG_DATA_W-1:0] reg_rd_data2;
    logic [REG_ADDR_W-1:0] ex_waddr;
    logic [REG_DATA_W-1:0] ex_wdata;
    logic                  ex_wen;
    logic [REG_ADDR_W-1:0] mem_waddr;
    logic [REG_DATA_W-1:0] mem_wdata;
    logic                  mem_wen;
    logic                  out_ack;
    logic                  out_req;
    logic [ALUOP_W-1:0]    out_aluop;
    logic [ALUSEL_W-1:0]   out_alusel;
    logic [REG_DATA_W-1:0] out_operand1;
    logic [REG_DATA_W-1:0] out_operand2;
    logic [REG_ADDR_W-1:0] out_wr_addr;
    logic                  out_wr_en;
    logic                  out_inst_valid;

    logic [REG_DATA_W-1:0] regs [32];
    fwd_t                  fwd;
    result_t               exp_q [$];
    logic [31:0]           seed = 32'd91;
    logic [31:0]           ack_seed = 32'd91;   // separate stream for the consumer.
    int                    cycle = 0;
    int                    req_cycle = 0;
    int                    test_err = 0;
    int                    pass_cnt = 0;
    int                    fail_cnt = 0;
    int                    rx_count = 0;
    logic                  ack_random = 1'b0;
    logic                  lat_check = 1'b0;
    logic                  overlap_seen = 1'b0;
    logic                  cons_busy = 1'b0;
    int                    n_rr = 40;
    int                    n_imm = 24;
    int                    n_ishift = 12;
    int                    n_fwd = 6;
    int                    n_burst = 30;
    int                    n_lat = 3;

    funct_e rr_functs [13] = '{FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
                               FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
    op_e    imm_ops [8]    = '{OP_ORI, OP_ANDI, OP_XORI, OP_LUI,
                               OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU};

    assign reg_rd_data1 = (reg_rd_addr1 == 5'd0) ? '0 : regs[reg_rd_addr1];
    assign reg_rd_data2 = (reg_rd_addr2 == 5'd0) ? '0 : regs[reg_rd_addr2];
    assign ex_waddr     = fwd.ex_a;
    assign ex_wdata     = fwd.ex_d;
    assign ex_wen       = fwd.ex_w;
    assign mem_waddr    = fwd.mem_a;
    assign mem_wdata    = fwd.mem_d;
    assign mem_wen      = fwd.mem_w;

    mips_id_top i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_req         (in_req),
        .inst           (inst),
        .reg_rd_data1   (reg_rd_data1),
        .reg_rd_data2   (reg_rd_data2),
        .ex_waddr       (ex_waddr),
        .ex_wdata       (ex_wdata),
        .ex_wen         (ex_wen),
        .mem_waddr      (mem_waddr),
        .mem_wdata      (mem_wdata),
        .mem_wen        (mem_wen),
        .out_ack        (out_ack),
        .in_ack         (in_ack),
        .reg_rd_addr1   (reg_rd_addr1),
        .reg_rd_addr2   (reg_rd_addr2),
        .out_req        (out_req),
        .out_aluop      (out_aluop),
        .out_alusel     (out_alusel),
        .out_operand1   (out_operand1),
        .out_operand2   (out_operand2),
        .out_wr_addr    (out_wr_addr),
        .out_wr_en      (out_wr_en),
        .out_inst_valid (out_inst_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] rand_word();
        seed = lcg_next(seed);
        return seed;
    endfunction

    function automatic logic [31:0] r_word(input logic [5:0] fn, input logic [4:0] rs,
            input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
            input logic [4:0] rt, input logic [15:0] im);
        return {op, rs, rt, im};
    endfunction

    function automatic logic [31:0] make_rr();
        logic [31:0] r;
        r = rand_word();
        return {OP_SPECIAL, r[25:11], 5'd0, rr_functs[r[31:28] % 4'd13]};
    endfunction

    function automatic logic [31:0] make_imm();
        logic [31:0] a;
        logic [31:0] b;
        a = rand_word();
        b = rand_word();
        return {imm_ops[a[30:28]], a[25:16], b[31:16]};
    endfunction

    // r0 reads zero and is never forwarded.
    function automatic logic [31:0] source_value(input logic [4:0] a,
            input logic [31:0] rf [32], input fwd_t f);
        if (a == 5'd0) return '0;
        if (f.ex_w && f.ex_a == a) return f.ex_d;
        if (f.mem_w && f.mem_a == a) return f.mem_d;
        return rf[a];
    endfunction

    function automatic result_t expect_result(input logic [31:0] word,
            input logic [31:0] rf [32], input fwd_t f);
        result_t    r;
        logic [5:0] op;
        logic [5:0] fn;
        logic       ishift;
        r      = '0;
        op     = word[31:26];
        fn     = word[5:0];
        ishift = (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA);
        if (op == OP_SPECIAL) begin
            case (fn)
                FN_SLL, FN_SLLV: r.aluop = ALU_SLL;
                FN_SRL, FN_SRLV: r.aluop = ALU_SRL;
                FN_SRA, FN_SRAV: r.aluop = ALU_SRA;
                FN_AND:          r.aluop = ALU_AND;
                FN_OR:           r.aluop = ALU_OR;
                FN_XOR:          r.aluop = ALU_XOR;
                FN_NOR:          r.aluop = ALU_NOR;
                FN_ADD:          r.aluop = ALU_ADD;
                FN_ADDU:         r.aluop = ALU_ADDU;
                FN_SUB:          r.aluop = ALU_SUB;
                FN_SUBU:         r.aluop = ALU_SUBU;
                FN_SLT:          r.aluop = ALU_SLT;
                FN_SLTU:         r.aluop = ALU_SLTU;
                default:         r.aluop = ALU_NOP;
            endcase
            // shifts sit below 8, logic at 36 to 39.
            r.alusel  = (fn < 6'd8) ? SEL_SHIFT :
                        (fn >= FN_AND && fn <= FN_NOR) ? SEL_LOGIC : SEL_ARITH;
            r.valid   = r.aluop != ALU_NOP &&
                        (ishift ? word[25:21] == 5'd0 : word[10:6] == 5'd0);
            r.op1     = ishift ? {27'd0, word[10:6]} : source_value(word[25:21], rf, f);
            r.op2     = source_value(word[20:16], rf, f);
            r.wr_addr = word[15:11];
        end else begin
            r.valid = 1'b1;
            case (op)
                OP_ORI, OP_LUI: r.aluop = ALU_OR;
                OP_ANDI:        r.aluop = ALU_AND;
                OP_XORI:        r.aluop = ALU_XOR;
                OP_SLTI:        r.aluop = ALU_SLT;
                OP_SLTIU:       r.aluop = ALU_SLTU;
                OP_ADDI:        r.aluop = ALU_ADD;
                OP_ADDIU:       r.aluop = ALU_ADDU;
                default:        r.valid = 1'b0;
            endcase
            r.alusel = (op >= OP_ANDI) ? SEL_LOGIC : SEL_ARITH;
            if (op == OP_LUI) begin
                r.op2 = {word[15:0], 16'h0};
            end else if (op >= OP_ANDI) begin
                r.op2 = {16'h0, word[15:0]};
            end else begin
                r.op2 = {{16{word[15]}}, word[15:0]};
            end
            r.op1     = source_value(word[25:21], rf, f);
            r.wr_addr = word[20:16];
        end
        r.wr_en = r.valid;
        if (!r.valid) r = '0;
        return r;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
            input logic [31:0] want);
        if (got !== want) begin
            $display("[ERROR] %s expected %h got %h", name, want, got);
            test_err++;
        end
    endtask

    task automatic send_inst(input logic [31:0] word);
        exp_q.push_back(expect_result(word, regs, fwd));
        inst      = word;
        in_req    = 1'b1;
        req_cycle = cycle;
        do begin
            @(posedge clk);
            #1;
        end while (!in_ack);
        if (out_req) overlap_seen = 1'b1;   // previous result still waiting.
        in_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (in_ack);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || cons_busy) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_err == 0) begin
            pass_cnt++;
            $display("test %s: pass", name);
        end else begin
            fail_cnt++;
            $display("test %s: fail with %0d errors", name, test_err);
        end
        test_err = 0;
    endtask

    initial begin : consumer
        result_t want;
        int      delay;
        out_ack = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (out_req) begin
                cons_busy = 1'b1;
                rx_count++;
                if (exp_q.size() == 0) begin
                    $display("a result arrived with no instruction outstanding");
                    test_err++;
                end else begin
                    want = exp_q.pop_front();
                    check_field("out_aluop", 32'(out_aluop), 32'(want.aluop));
                    check_field("out_alusel", 32'(out_alusel), 32'(want.alusel));
                    check_field("out_operand1", out_operand1, want.op1);
                    check_field("out_operand2", out_operand2, want.op2);
                    check_field("out_wr_addr", 32'(out_wr_addr), 32'(want.wr_addr));
                    check_field("out_wr_en", 32'(out_wr_en), 32'(want.wr_en));
                    check_field("out_inst_valid", 32'(out_inst_valid), 32'(want.valid));
                end
                if (lat_check && cycle - req_cycle != 2) begin
                    $display("out_req rose %0d cycles after in_req, not 2", cycle - req_cycle);
                    test_err++;
                end
                ack_seed = lcg_next(ack_seed);
                delay    = ack_random ? int'((ack_seed >> 16) % 11) : 0;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                out_ack = 1'b1;
                do begin
                    @(posedge clk);
                    #1;
                end while (out_req);
                out_ack   = 1'b0;
                cons_busy = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat ((n_rr + n_imm + n_ishift + n_fwd + n_burst + n_lat) * 20 + 200) begin
            @(posedge clk);
        end
        $display("timeout, a handshake never completed");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : main_seq
        logic [31:0] a;
        logic [15:0] im;
        rst_n  = 1'b0;
        in_req = 1'b0;
        inst   = '0;
        fwd    = '0;
        for (int i = 0; i < 32; i++) regs[i[4:0]] = rand_word();
        regs[0] = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_field("in_ack", 32'(in_ack), 32'h0);
        check_field("out_req", 32'(out_req), 32'h0);
        check_field("out_aluop", 32'(out_aluop), 32'h0);
        check_field("out_alusel", 32'(out_alusel), 32'h0);
        check_field("out_operand1", out_operand1, 32'h0);
        check_field("out_operand2", out_operand2, 32'h0);
        check_field("out_wr_addr", 32'(out_wr_addr), 32'h0);
        check_field("out_wr_en", 32'(out_wr_en), 32'h0);
        check_field("out_inst_valid", 32'(out_inst_valid), 32'h0);
        finish_test("1 reset values");

        repeat (n_rr) send_inst(make_rr());
        wait_drain();
        finish_test("2 register-register ops");

        for (int k = 0; k < 8; k++) begin
            for (int j = 0; j < 3; j++) begin
                a  = rand_word();
                im = (j == 0) ? 16'h8001 : (j == 1) ? 16'hfffe : a[31:16];
                send_inst(i_word(imm_ops[k[2:0]], a[25:21], a[20:16], im));
            end
        end
        wait_drain();
        finish_test("3 immediate ops");

        repeat (2) begin
            a = rand_word();
            send_inst(r_word(FN_SLL, 5'd0, a[20:16], a[15:11], a[10:6]));
            send_inst(r_word(FN_SRL, 5'd0, a[25:21], a[15:11], a[30:26]));
            send_inst(r_word(FN_SRA, 5'd0, a[20:16], a[30:26], a[10:6]));
        end
        send_inst(32'h0800_0010);                           // jump, dropped.
        send_inst(i_word(6'h23, 5'd1, 5'd2, 16'h0004));     // load word.
        send_inst(r_word(FN_SLL, 5'd3, 5'd4, 5'd5, 5'd2));  // rs must be zero.
        send_inst(r_word(FN_ADD, 5'd1, 5'd2, 5'd3, 5'd4));  // shamt must be zero.
        send_inst(r_word(6'd8, 5'd31, 5'd0, 5'd0, 5'd0));
        send_inst(r_word(6'd24, 5'd4, 5'd5, 5'd0, 5'd0));
        wait_drain();
        finish_test("4 immediate shifts and invalid codes");

        fwd = '{5'd7, 32'hcafe_0001, 1'b1, 5'd7, 32'hbeef_0002, 1'b1};
        send_inst(r_word(FN_ADD, 5'd7, 5'd8, 5'd9, 5'd0));
        send_inst(r_word(FN_SUB, 5'd8, 5'd7, 5'd10, 5'd0));
        wait_drain();
        fwd = '{5'd8, 32'hcafe_0003, 1'b0, 5'd8, 32'hbeef_0004, 1'b1};
        send_inst(r_word(FN_OR, 5'd8, 5'd3, 5'd4, 5'd0));
        wait_drain();
        fwd = '{5'd0, 32'hcafe_0005, 1'b1, 5'd0, 32'hbeef_0006, 1'b1};
        send_inst(r_word(FN_XOR, 5'd0, 5'd0, 5'd1, 5'd0));
        wait_drain();
        fwd = '{5'd6, 32'hcafe_0007, 1'b1, 5'd0, 32'h0, 1'b0};
        send_inst(i_word(OP_ORI, 5'd2, 5'd6, 16'h1234));   // rt is the target here.
        send_inst(r_word(FN_SLL, 5'd0, 5'd6, 5'd6, 5'd3));
        wait_drain();
        fwd = '0;
        finish_test("5 forwarding");

        ack_random   = 1'b1;
        rx_count     = 0;
        overlap_seen = 1'b0;
        repeat (n_burst) begin
            a = rand_word();
            send_inst(a[31] ? make_rr() : make_imm());
        end
        wait_drain();
        ack_random = 1'b0;
        if (rx_count != n_burst) begin
            $display("burst gave %0d results for %0d instructions", rx_count, n_burst);
            test_err++;
        end
        if (!overlap_seen) begin
            $display("in_ack never rose while an earlier result was waiting");
            test_err++;
        end
        lat_check = 1'b1;
        repeat (n_lat) begin
            send_inst(make_rr());
            wait_drain();
        end
        lat_check = 1'b0;
        finish_test("6 back-pressure and latency");

        $display("tests passed %0d, tests failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== mips_id_top.sv ====
module mips_id_top import mips_id_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_req,
    input  logic [INST_W-1:0]     inst,
    input  logic [REG_DATA_W-1:0] reg_rd_data1,
    input  logic [REG_DATA_W-1:0] reg_rd_data2,
    input  logic [REG_ADDR_W-1:0] ex_waddr,
    input  logic [REG_DATA_W-1:0] ex_wdata,
    input  logic                  ex_wen,
    input  logic [REG_ADDR_W-1:0] mem_waddr,
    input  logic [REG_DATA_W-1:0] mem_wdata,
    input  logic                  mem_wen,
    input  logic                  out_ack,
    output logic                  in_ack,
    output logic [REG_ADDR_W-1:0] reg_rd_addr1,
    output logic [REG_ADDR_W-1:0] reg_rd_addr2,
    output logic                  out_req,
    output logic [ALUOP_W-1:0]    out_aluop,
    output logic [ALUSEL_W-1:0]   out_alusel,
    output logic [REG_DATA_W-1:0] out_operand1,
    output logic [REG_DATA_W-1:0] out_operand2,
    output logic [REG_ADDR_W-1:0] out_wr_addr,
    output logic                  out_wr_en,
    output logic                  out_inst_valid
);

    logic [INST_W-1:0] held_inst;
    logic              held;
    logic              take;

    decode_if d_if ();

    assign reg_rd_addr1 = d_if.rs_addr;
    assign reg_rd_addr2 = d_if.rt_addr;

    inst_intake i_intake (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_req    (in_req),
        .inst      (inst),
        .take      (take),
        .in_ack    (in_ack),
        .held_inst (held_inst),
        .held      (held)
    );

    inst_decoder i_decoder (
        .held_inst (held_inst),
        .dec       (d_if.dec)
    );

    operand_issue i_issue (
        .clk            (clk),
        .rst_n          (rst_n),
        .held           (held),
        .iss            (d_if.iss),
        .reg_rd_data1   (reg_rd_data1),
        .reg_rd_data2   (reg_rd_data2),
        .ex_wdata       (ex_wdata),
        .mem_wdata      (mem_wdata),
        .ex_waddr       (ex_waddr),
        .mem_waddr      (mem_waddr),
        .ex_wen         (ex_wen),
        .mem_wen        (mem_wen),
        .out_ack        (out_ack),
        .take           (take),
        .out_req        (out_req),
        .out_aluop      (out_aluop),
        .out_alusel     (out_alusel),
        .out_operand1   (out_operand1),
        .out_operand2   (out_operand2),
        .out_wr_addr    (out_wr_addr),
        .out_wr_en      (out_wr_en),
        .out_inst_valid (out_inst_valid)
    );

endmodule

// ==== operand_issue.sv ====
module operand_issue import mips_id_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  held,
    decode_if.iss                 iss,
    input  logic [REG_DATA_W-1:0] reg_rd_data1,
    input  logic [REG_DATA_W-1:0] reg_rd_data2,
    input  logic [REG_DATA_W-1:0] ex_wdata,
    input  logic [REG_DATA_W-1:0] mem_wdata,
    input  logic [REG_ADDR_W-1:0] ex_waddr,
    input  logic [REG_ADDR_W-1:0] mem_waddr,
    input  logic                  ex_wen,
    input  logic                  mem_wen,
    input  logic                  out_ack,
    output logic                  take,
    output logic                  out_req,
    output aluop_e                out_aluop,
    output alusel_e               out_alusel,
    output logic [REG_DATA_W-1:0] out_operand1,
    output logic [REG_DATA_W-1:0] out_operand2,
    output logic [REG_ADDR_W-1:0] out_wr_addr,
    output logic                  out_wr_en,
    output logic                  out_inst_valid
);

    typedef enum logic {
        TX_IDLE,
        TX_REQ
    } tx_state_e;

    tx_state_e             state;
    logic [REG_DATA_W-1:0] operand1;
    logic [REG_DATA_W-1:0] operand2;

    // execute wins over memory; r0 is never forwarded.
    function automatic logic [REG_DATA_W-1:0] pick_operand(
        input logic                  rd_en,
        input logic [REG_ADDR_W-1:0] addr,
        input logic [REG_DATA_W-1:0] rf_data,
        input logic [REG_DATA_W-1:0] imm
    );
        logic [REG_DATA_W-1:0] val;
        if (!rd_en) begin
            val = imm;
        end else if (ex_wen && addr != '0 && addr == ex_waddr) begin
            val = ex_wdata;
        end else if (mem_wen && addr != '0 && addr == mem_waddr) begin
            val = mem_wdata;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    always_comb begin
        operand1 = '0;
        operand2 = '0;
        if (iss.inst_valid) begin
            operand1 = pick_operand(iss.rd_en1, iss.rs_addr, reg_rd_data1, iss.imm);
            operand2 = pick_operand(iss.rd_en2, iss.rt_addr, reg_rd_data2, iss.imm);
        end
    end

    // load only with the previous handshake fully closed.
    assign take    = held && (state == TX_IDLE) && !out_ack;
    assign out_req = (state == TX_REQ);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= TX_IDLE;
            out_aluop      <= ALU_NOP;
            out_alusel     <= SEL_NOP;
            out_operand1   <= '0;
            out_operand2   <= '0;
            out_wr_addr    <= '0;
            out_wr_en      <= 1'b0;
            out_inst_valid <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (take) begin
                        state          <= TX_REQ;
                        out_aluop      <= iss.inst_valid ? iss.aluop : ALU_NOP;
                        out_alusel     <= iss.inst_valid ? iss.alusel : SEL_NOP;
                        out_operand1   <= operand1;
                        out_operand2   <= operand2;
                        out_wr_addr    <= iss.inst_valid ? iss.wr_addr : '0;
                        out_wr_en      <= iss.inst_valid && iss.wr_en;
                        out_inst_valid <= iss.inst_valid;
                    end
                end
                TX_REQ: begin
                    if (out_ack) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // the consumer must see every result.
    a_req_holds: assert property (@(posedge clk) disable iff (!rst_n)
        out_req && !out_ack |=> out_req);

endmodule

// ==== inst_decoder.sv ====
module inst_decoder import mips_id_pkg::*; (
    input  logic [INST_W-1:0] held_inst,
    decode_if.dec             dec
);

    op_e                   op;
    funct_e                funct;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] shamt;
    logic [IMM_W-1:0]      im;
    logic                  imm_shift;

    aluop_e                r_aluop;
    alusel_e               r_alusel;
    aluop_e                i_aluop;
    alusel_e               i_alusel;
    logic [REG_DATA_W-1:0] i_imm;
    logic                  i_valid;

    assign op    = op_e'(held_inst[OP_MSB:OP_LSB]);
    assign rs    = held_inst[RS_LSB +: REG_ADDR_W];
    assign rt    = held_inst[RT_LSB +: REG_ADDR_W];
    assign rd    = held_inst[RD_LSB +: REG_ADDR_W];
    assign shamt = held_inst[SHAMT_LSB +: REG_ADDR_W];
    assign funct = funct_e'(held_inst[FUNCT_W-1:0]);
    assign im    = held_inst[IMM_W-1:0];

    assign imm_shift = funct inside {FN_SLL, FN_SRL, FN_SRA};

    // read ports follow the fields whatever the opcode.
    assign dec.rs_addr = rs;
    assign dec.rt_addr = rt;

    // register-register forms.
    always_comb begin
        r_aluop  = ALU_NOP;
        r_alusel = SEL_NOP;
        case (funct)
            FN_SLL, FN_SLLV: begin r_aluop = ALU_SLL;  r_alusel = SEL_SHIFT; end
            FN_SRL, FN_SRLV: begin r_aluop = ALU_SRL;  r_alusel = SEL_SHIFT; end
            FN_SRA, FN_SRAV: begin r_aluop = ALU_SRA;  r_alusel = SEL_SHIFT; end
            FN_AND:          begin r_aluop = ALU_AND;  r_alusel = SEL_LOGIC; end
            FN_OR:           begin r_aluop = ALU_OR;   r_alusel = SEL_LOGIC; end
            FN_XOR:          begin r_aluop = ALU_XOR;  r_alusel = SEL_LOGIC; end
            FN_NOR:          begin r_aluop = ALU_NOR;  r_alusel = SEL_LOGIC; end
            FN_ADD:          begin r_aluop = ALU_ADD;  r_alusel = SEL_ARITH; end
            FN_ADDU:         begin r_aluop = ALU_ADDU; r_alusel = SEL_ARITH; end
            FN_SUB:          begin r_aluop = ALU_SUB;  r_alusel = SEL_ARITH; end
            FN_SUBU:         begin r_aluop = ALU_SUBU; r_alusel = SEL_ARITH; end
            FN_SLT:          begin r_aluop = ALU_SLT;  r_alusel = SEL_ARITH; end
            FN_SLTU:         begin r_aluop = ALU_SLTU; r_alusel = SEL_ARITH; end
            default: ;
        endcase
    end

    // immediate forms, rs op imm into rt.
    always_comb begin
        i_aluop  = ALU_NOP;
        i_alusel = SEL_NOP;
        i_imm    = '0;
        i_valid  = 1'b1;
        case (op)
            OP_ORI: begin
                i_aluop  = ALU_OR;
                i_alusel = SEL_LOGIC;
                i_imm    = {{(REG_DATA_W-IMM_W){1'b0}}, im};
            end
            OP_ANDI: begin
                i_aluop  = ALU_AND;
                i_alusel = SEL_LOGIC;
                i_imm    = {{(REG_DATA_W-IMM_W){1'b0}}, im};
            end
            OP_XORI: begin
                i_aluop  = ALU_XOR;
                i_alusel = SEL_LOGIC;
                i_imm    = {{(REG_DATA_W-IMM_W){1'b0}}, im};
            end
            OP_LUI: begin
                i_aluop  = ALU_OR;
                i_alusel = SEL_LOGIC;
                i_imm    = {im, {(REG_DATA_W-IMM_W){1'b0}}};   // upper half.
            end
            OP_SLTI: begin
                i_aluop  = ALU_SLT;
                i_alusel = SEL_ARITH;
                i_imm    = {{(REG_DATA_W-IMM_W){im[IMM_W-1]}}, im};
            end
            OP_SLTIU: begin
                i_aluop  = ALU_SLTU;
                i_alusel = SEL_ARITH;
                i_imm    = {{(REG_DATA_W-IMM_W){im[IMM_W-1]}}, im};
            end
            OP_ADDI: begin
                i_aluop  = ALU_ADD;
                i_alusel = SEL_ARITH;
                i_imm    = {{(REG_DATA_W-IMM_W){im[IMM_W-1]}}, im};
            end
            OP_ADDIU: begin
                i_aluop  = ALU_ADDU;
                i_alusel = SEL_ARITH;
                i_imm    = {{(REG_DATA_W-IMM_W){im[IMM_W-1]}}, im};
            end
            default: i_valid = 1'b0;
        endcase
    end

    always_comb begin
        dec.aluop      = ALU_NOP;
        dec.alusel     = SEL_NOP;
        dec.rd_en1     = 1'b0;
        dec.rd_en2     = 1'b0;
        dec.wr_addr    = rd;
        dec.wr_en      = 1'b0;
        dec.imm        = '0;
        dec.inst_valid = 1'b0;
        if (op == OP_SPECIAL) begin
            // immediate shifts need rs zero, the rest need shamt zero.
            if (r_alusel != SEL_NOP && (imm_shift ? rs == '0 : shamt == '0)) begin
                dec.aluop      = r_aluop;
                dec.alusel     = r_alusel;
                dec.rd_en1     = !imm_shift;
                dec.rd_en2     = 1'b1;
                dec.wr_en      = 1'b1;
                dec.inst_valid = 1'b1;
                if (imm_shift) begin
                    dec.imm = {{(REG_DATA_W-REG_ADDR_W){1'b0}}, shamt};
                end
            end
        end else if (i_valid) begin
            dec.aluop      = i_aluop;
            dec.alusel     = i_alusel;
            dec.rd_en1     = 1'b1;
            dec.wr_addr    = rt;
            dec.wr_en      = 1'b1;
            dec.imm        = i_imm;
            dec.inst_valid = 1'b1;
        end
    end

    // a valid decode always names an operation and its group.
    always_comb begin
        assert (!dec.inst_valid || (dec.aluop != ALU_NOP && dec.alusel != SEL_NOP))
            else $error("valid instruction decoded with a nop code.");
    end

endmodule

// ==== inst_intake.sv ====
module inst_intake import mips_id_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_req,
    input  logic [INST_W-1:0] inst,
    input  logic              take,
    output logic              in_ack,
    output logic [INST_W-1:0] held_inst,
    output logic              held
);

    typedef enum logic {
        RX_IDLE,
        RX_ACK
    } rx_state_e;

    rx_state_e state;
    logic      capture;

    // new word only when idle and the slot is empty.
    assign capture = (state == RX_IDLE) && in_req && !held;
    assign in_ack  = (state == RX_ACK);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= RX_IDLE;
            held  <= 1'b0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (capture) begin
                        state <= RX_ACK;
                    end
                end
                RX_ACK: begin
                    if (!in_req) begin
                        state <= RX_IDLE;   // producer withdrew, drop ack.
                    end
                end
                default: state <= RX_IDLE;
            endcase
            if (capture) begin
                held <= 1'b1;
            end else if (take) begin
                held <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            held_inst <= inst;
        end
    end

    // four-phase rule on the producer side.
    a_ack_holds: assert property (@(posedge clk) disable iff (!rst_n)
        in_req && in_ack |=> in_ack);

endmodule

// ==== decode_if.sv ====
interface decode_if import mips_id_pkg::*; ();

    aluop_e                aluop;
    alusel_e               alusel;
    logic                  rd_en1;     // rs is a source.
    logic                  rd_en2;     // rt is a source.
    logic [REG_ADDR_W-1:0] rs_addr;
    logic [REG_ADDR_W-1:0] rt_addr;
    logic [REG_ADDR_W-1:0] wr_addr;
    logic                  wr_en;
    logic [REG_DATA_W-1:0] imm;
    logic                  inst_valid;

    modport dec (
        output aluop, alusel, rd_en1, rd_en2, rs_addr, rt_addr,
        output wr_addr, wr_en, imm, inst_valid
    );

    modport iss (
        input aluop, alusel, rd_en1, rd_en2, rs_addr, rt_addr,
        input wr_addr, wr_en, imm, inst_valid
    );

endinterface

// ==== mips_id_pkg.sv ====
package mips_id_pkg;

    // data path widths.
    localparam int INST_W     = 32;
    localparam int REG_DATA_W = 32;
    localparam int REG_ADDR_W = 5;

    // code widths.
    localparam int OP_W     = 6;
    localparam int FUNCT_W  = 6;   // funct sits in the low bits.
    localparam int ALUOP_W  = 4;
    localparam int ALUSEL_W = 2;

    // instruction word layout, op | rs | rt | rd | shamt | funct.
    localparam int OP_MSB    = 31;
    localparam int OP_LSB    = 26;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int SHAMT_LSB = 6;
    localparam int IMM_W     = 16;

    // primary opcodes kept by this stage.
    typedef enum logic [OP_W-1:0] {
        OP_SPECIAL = 6'd0,
        OP_ADDI    = 6'd8,
        OP_ADDIU   = 6'd9,
        OP_SLTI    = 6'd10,
        OP_SLTIU   = 6'd11,
        OP_ANDI    = 6'd12,
        OP_ORI     = 6'd13,
        OP_XORI    = 6'd14,
        OP_LUI     = 6'd15
    } op_e;

    // function codes under SPECIAL.
    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_SLLV = 6'd4,
        FN_SRLV = 6'd6,
        FN_SRAV = 6'd7,
        FN_ADD  = 6'd32,
        FN_ADDU = 6'd33,
        FN_SUB  = 6'd34,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_NOR  = 6'd39,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_e;

    typedef enum logic [ALUOP_W-1:0] {
        ALU_NOP,
        ALU_OR,
        ALU_AND,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_ADD,
        ALU_ADDU,
        ALU_SUB,
        ALU_SUBU
    } aluop_e;

    // result group for the execute stage.
    typedef enum logic [ALUSEL_W-1:0] {
        SEL_NOP,
        SEL_LOGIC,
        SEL_SHIFT,
        SEL_ARITH
    } alusel_e;

endpackage
